// File: include/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define DEC_INSTR_W     32
`define DEC_ALU_OP_W    5
`define DEC_RD_FIELD    4:0

// major fields and class codes
`define DEC_3R_MAJ      31:22
`define DEC_3R_CODE     10'b00_0000_0000
`define DEC_2RI8_MAJ    31:22
`define DEC_2RI8_CODE   10'b00_0000_0001
`define DEC_2RI12_MAJ   31:25
`define DEC_2RI12_CODE  7'b000_0001
`define DEC_U_MAJ       31:28
`define DEC_U_CODE      4'b0001
`define DEC_MEM_MAJ     31:26
`define DEC_MEM_CODE    6'b00_1010
`define DEC_BR_MAJ      31:30
`define DEC_BR_CODE     2'b01

// minor fields
`define DEC_3R_MIN      21:15
`define DEC_2RI8_MIN    21:15
`define DEC_2RI12_MIN   24:22
`define DEC_U_MIN       27:25
`define DEC_MEM_MIN     25:22
`define DEC_BR_MIN      29:26

// 3R minor codes
`define DEC_ADD         7'h20
`define DEC_SUB         7'h22
`define DEC_SLT         7'h24
`define DEC_SLTU        7'h25
`define DEC_NOR         7'h28
`define DEC_AND         7'h29
`define DEC_OR          7'h2a
`define DEC_XOR         7'h2b
`define DEC_SLL         7'h2e
`define DEC_SRL         7'h2f
`define DEC_SRA         7'h30
`define DEC_MUL         7'h38
`define DEC_MULH        7'h39
`define DEC_MULHU       7'h3a
`define DEC_DIV         7'h40
`define DEC_MOD         7'h41
`define DEC_DIVU        7'h42
`define DEC_MODU        7'h43

// shift immediate, bit 15 of the word is part of the code
`define DEC_SLLI        7'h01
`define DEC_SRLI        7'h09
`define DEC_SRAI        7'h11

`define DEC_SLTI        3'b000
`define DEC_SLTUI       3'b001
`define DEC_ADDI        3'b010
`define DEC_ANDI        3'b101
`define DEC_ORI         3'b110
`define DEC_XORI        3'b111

`define DEC_LUI         3'b010
`define DEC_PCADDU12I   3'b110

`define DEC_LD_B        4'b0000
`define DEC_LD_H        4'b0001
`define DEC_LD_W        4'b0010
`define DEC_ST_B        4'b0100
`define DEC_ST_H        4'b0101
`define DEC_ST_W        4'b0110
`define DEC_LD_BU       4'b1000
`define DEC_LD_HU       4'b1001

`define DEC_JIRL        4'b0011
`define DEC_B           4'b0100
`define DEC_BL          4'b0101
`define DEC_BEQ         4'b0110
`define DEC_BNE         4'b0111
`define DEC_BLT         4'b1000
`define DEC_BGE         4'b1001
`define DEC_BLTU        4'b1010
`define DEC_BGEU        4'b1011

`endif

// File: rtl/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

    typedef logic [`DEC_INSTR_W-1:0] instr_t;

    // one identity per kept instruction
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_NOR, OP_AND,
        OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
        OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_MOD, OP_DIVU, OP_MODU,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_SLTI, OP_SLTUI, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_LUI, OP_PCADDU12I,
        OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
        OP_ST_B, OP_ST_H, OP_ST_W,
        OP_B, OP_BL, OP_JIRL,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_ILLEGAL
    } op_id_t;

    typedef enum logic [3:0] {
        GRP_REG, GRP_SHAMT, GRP_REGIMM, GRP_UPPER,
        GRP_LOAD, GRP_STORE, GRP_JUMP, GRP_BRANCH,
        GRP_NONE
    } instr_group_t;

    typedef enum logic {
        PC_ADD4,
        PC_BRANCH
    } pc_sel_t;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I8, IMM_I12, IMM_I16, IMM_I20, IMM_I26
    } imm_type_t;

    typedef enum logic [1:0] {
        SRC1_NONE,
        SRC1_RJ,
        SRC1_PC
    } alu_src1_t;

    typedef enum logic [1:0] {
        SRC2_NONE,
        SRC2_RK,
        SRC2_IMM
    } alu_src2_t;

    typedef enum logic [`DEC_ALU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHU, ALU_DIV, ALU_MOD, ALU_DIVU, ALU_MODU,
        // return address for bl and jirl
        ALU_PCADD4,
        ALU_LUI
    } alu_op_t;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_t;

endpackage

// File: rtl/instr_class_if.sv
// decoded identity, combinational from the instruction word
interface instr_class_if;
    import decode_pkg::*;

    op_id_t       op;
    instr_group_t group;
    logic         illegal;
    // writes to r0 are dropped
    logic         rd_nonzero;

    modport producer (
        output op,
        output group,
        output illegal,
        output rd_nonzero
    );

    modport consumer (
        input op,
        input group,
        input illegal,
        input rd_nonzero
    );

endinterface

// File: rtl/opcode_decoder.sv
`include "decode_config.svh"

module opcode_decoder (
    input  decode_pkg::instr_t instr,
    instr_class_if.producer    cls
);
    import decode_pkg::*;

    op_id_t       op;
    instr_group_t grp;

    // major field picks the class, minor field the instruction
    always_comb begin
        op = OP_ILLEGAL;
        if (instr[`DEC_3R_MAJ] == `DEC_3R_CODE) begin
            case (instr[`DEC_3R_MIN])
                `DEC_ADD:   op = OP_ADD;
                `DEC_SUB:   op = OP_SUB;
                `DEC_SLT:   op = OP_SLT;
                `DEC_SLTU:  op = OP_SLTU;
                `DEC_NOR:   op = OP_NOR;
                `DEC_AND:   op = OP_AND;
                `DEC_OR:    op = OP_OR;
                `DEC_XOR:   op = OP_XOR;
                `DEC_SLL:   op = OP_SLL;
                `DEC_SRL:   op = OP_SRL;
                `DEC_SRA:   op = OP_SRA;
                `DEC_MUL:   op = OP_MUL;
                `DEC_MULH:  op = OP_MULH;
                `DEC_MULHU: op = OP_MULHU;
                `DEC_DIV:   op = OP_DIV;
                `DEC_MOD:   op = OP_MOD;
                `DEC_DIVU:  op = OP_DIVU;
                `DEC_MODU:  op = OP_MODU;
                default:    op = OP_ILLEGAL;
            endcase
        end else if (instr[`DEC_2RI8_MAJ] == `DEC_2RI8_CODE) begin
            case (instr[`DEC_2RI8_MIN])
                `DEC_SLLI:  op = OP_SLLI;
                `DEC_SRLI:  op = OP_SRLI;
                `DEC_SRAI:  op = OP_SRAI;
                default:    op = OP_ILLEGAL;
            endcase
        end else if (instr[`DEC_2RI12_MAJ] == `DEC_2RI12_CODE) begin
            // 3'b011 and 3'b100 are not used
            case (instr[`DEC_2RI12_MIN])
                `DEC_SLTI:  op = OP_SLTI;
                `DEC_SLTUI: op = OP_SLTUI;
                `DEC_ADDI:  op = OP_ADDI;
                `DEC_ANDI:  op = OP_ANDI;
                `DEC_ORI:   op = OP_ORI;
                `DEC_XORI:  op = OP_XORI;
                default:    op = OP_ILLEGAL;
            endcase
        end else if (instr[`DEC_U_MAJ] == `DEC_U_CODE) begin
            case (instr[`DEC_U_MIN])
                `DEC_LUI:       op = OP_LUI;
                `DEC_PCADDU12I: op = OP_PCADDU12I;
                default:        op = OP_ILLEGAL;
            endcase
        end else if (instr[`DEC_MEM_MAJ] == `DEC_MEM_CODE) begin
            case (instr[`DEC_MEM_MIN])
                `DEC_LD_B:  op = OP_LD_B;
                `DEC_LD_H:  op = OP_LD_H;
                `DEC_LD_W:  op = OP_LD_W;
                `DEC_LD_BU: op = OP_LD_BU;
                `DEC_LD_HU: op = OP_LD_HU;
                `DEC_ST_B:  op = OP_ST_B;
                `DEC_ST_H:  op = OP_ST_H;
                `DEC_ST_W:  op = OP_ST_W;
                default:    op = OP_ILLEGAL;
            endcase
        end else if (instr[`DEC_BR_MAJ] == `DEC_BR_CODE) begin
            case (instr[`DEC_BR_MIN])
                `DEC_JIRL:  op = OP_JIRL;
                `DEC_B:     op = OP_B;
                `DEC_BL:    op = OP_BL;
                `DEC_BEQ:   op = OP_BEQ;
                `DEC_BNE:   op = OP_BNE;
                `DEC_BLT:   op = OP_BLT;
                `DEC_BGE:   op = OP_BGE;
                `DEC_BLTU:  op = OP_BLTU;
                `DEC_BGEU:  op = OP_BGEU;
                default:    op = OP_ILLEGAL;
            endcase
        end
    end

    // group lookup, anything not listed counts as illegal
    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_NOR, OP_AND, OP_OR, OP_XOR,
            OP_SLL, OP_SRL, OP_SRA, OP_MUL, OP_MULH, OP_MULHU,
            OP_DIV, OP_MOD, OP_DIVU, OP_MODU:
                grp = GRP_REG;
            OP_SLLI, OP_SRLI, OP_SRAI:
                grp = GRP_SHAMT;
            OP_SLTI, OP_SLTUI, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI:
                grp = GRP_REGIMM;
            OP_LUI, OP_PCADDU12I:
                grp = GRP_UPPER;
            OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU:
                grp = GRP_LOAD;
            OP_ST_B, OP_ST_H, OP_ST_W:
                grp = GRP_STORE;
            OP_B, OP_BL, OP_JIRL:
                grp = GRP_JUMP;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                grp = GRP_BRANCH;
            default:
                grp = GRP_NONE;
        endcase
    end

    assign cls.op         = op;
    assign cls.group      = grp;
    assign cls.illegal    = (grp == GRP_NONE);
    assign cls.rd_nonzero = |instr[`DEC_RD_FIELD];

    // an op missing from the group lookup would show up here
    always_comb begin
        assert final (cls.illegal == (op == OP_ILLEGAL))
            else $error("opcode_decoder: group lookup disagrees with op");
    end

endmodule

// File: rtl/datapath_ctrl.sv
module datapath_ctrl (
    instr_class_if.consumer        cls,
    output decode_pkg::imm_type_t  imm_type,
    output logic                   imm_unsigned,
    output decode_pkg::alu_src1_t  alu_src1,
    output decode_pkg::alu_src2_t  alu_src2,
    output decode_pkg::alu_op_t    alu_op,
    output decode_pkg::wb_sel_t    wb_sel,
    output logic                   reg_write_en,
    output logic                   mem_read,
    output logic                   mem_write_en,
    output decode_pkg::mem_size_t  mem_size,
    output logic                   load_unsigned
);
    import decode_pkg::*;

    // operands, immediate format and enables per group
    always_comb begin
        imm_type     = IMM_NONE;
        alu_src1     = SRC1_NONE;
        alu_src2     = SRC2_NONE;
        wb_sel       = WB_ALU;
        reg_write_en = 1'b0;
        mem_read     = 1'b0;
        mem_write_en = 1'b0;
        case (cls.group)
            GRP_REG: begin
                alu_src1     = SRC1_RJ;
                alu_src2     = SRC2_RK;
                reg_write_en = cls.rd_nonzero;
            end
            GRP_SHAMT: begin
                imm_type     = IMM_I8;
                alu_src1     = SRC1_RJ;
                alu_src2     = SRC2_IMM;
                reg_write_en = cls.rd_nonzero;
            end
            GRP_REGIMM: begin
                imm_type     = IMM_I12;
                alu_src1     = SRC1_RJ;
                alu_src2     = SRC2_IMM;
                reg_write_en = cls.rd_nonzero;
            end
            GRP_UPPER: begin
                imm_type     = IMM_I20;
                alu_src1     = (cls.op == OP_PCADDU12I) ? SRC1_PC : SRC1_NONE;
                alu_src2     = SRC2_IMM;
                reg_write_en = cls.rd_nonzero;
            end
            GRP_LOAD: begin
                imm_type     = IMM_I12;
                alu_src1     = SRC1_RJ;
                alu_src2     = SRC2_IMM;
                wb_sel       = WB_MEM;
                reg_write_en = cls.rd_nonzero;
                mem_read     = 1'b1;
            end
            GRP_STORE: begin
                imm_type     = IMM_I12;
                alu_src1     = SRC1_RJ;
                alu_src2     = SRC2_IMM;
                mem_write_en = 1'b1;
            end
            GRP_JUMP: begin
                imm_type     = (cls.op == OP_JIRL) ? IMM_I16 : IMM_I26;
                alu_src1     = (cls.op == OP_B) ? SRC1_NONE : SRC1_PC;
                // bl links to r1, its rd field is not a register
                reg_write_en = (cls.op == OP_BL) ||
                               ((cls.op == OP_JIRL) && cls.rd_nonzero);
            end
            GRP_BRANCH: begin
                imm_type = IMM_I16;
            end
            default: begin
                imm_type = IMM_NONE;
            end
        endcase
    end

    always_comb begin
        case (cls.op)
            OP_SUB:                          alu_op = ALU_SUB;
            OP_SLT, OP_SLTI:                 alu_op = ALU_SLT;
            OP_SLTU, OP_SLTUI:               alu_op = ALU_SLTU;
            OP_NOR:                          alu_op = ALU_NOR;
            OP_AND, OP_ANDI:                 alu_op = ALU_AND;
            OP_OR, OP_ORI:                   alu_op = ALU_OR;
            OP_XOR, OP_XORI:                 alu_op = ALU_XOR;
            OP_SLL, OP_SLLI:                 alu_op = ALU_SLL;
            OP_SRL, OP_SRLI:                 alu_op = ALU_SRL;
            OP_SRA, OP_SRAI:                 alu_op = ALU_SRA;
            OP_MUL:                          alu_op = ALU_MUL;
            OP_MULH:                         alu_op = ALU_MULH;
            OP_MULHU:                        alu_op = ALU_MULHU;
            OP_DIV:                          alu_op = ALU_DIV;
            OP_MOD:                          alu_op = ALU_MOD;
            OP_DIVU:                         alu_op = ALU_DIVU;
            OP_MODU:                         alu_op = ALU_MODU;
            OP_BL, OP_JIRL:                  alu_op = ALU_PCADD4;
            OP_LUI:                          alu_op = ALU_LUI;
            // add, addi, pcaddu12i and address generation
            default:                         alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (cls.op)
            OP_LD_H, OP_LD_HU, OP_ST_H: mem_size = SIZE_HALF;
            OP_LD_W, OP_ST_W:           mem_size = SIZE_WORD;
            default:                    mem_size = SIZE_BYTE;
        endcase
    end

    assign load_unsigned = (cls.op == OP_LD_BU) || (cls.op == OP_LD_HU);

    // logical immediates are zero extended
    assign imm_unsigned = (cls.op == OP_ANDI) || (cls.op == OP_ORI) || (cls.op == OP_XORI);

    always_comb begin
        assert final (!(mem_read && mem_write_en))
            else $error("datapath_ctrl: load and store enabled together");
    end

endmodule

// File: rtl/branch_ctrl.sv
module branch_ctrl (
    instr_class_if.consumer      cls,
    input  logic                 eq,
    input  logic                 lt,
    output decode_pkg::pc_sel_t  pc_sel,
    output logic                 unsigned_cmp,
    output logic                 link,
    output logic                 target_from_reg
);
    import decode_pkg::*;

    logic taken;

    always_comb begin
        case (cls.op)
            OP_B, OP_BL, OP_JIRL: taken = 1'b1;
            OP_BEQ:               taken = eq;
            OP_BNE:               taken = !eq;
            // lt already reflects unsigned_cmp for bltu and bgeu
            OP_BLT, OP_BLTU:      taken = lt;
            OP_BGE, OP_BGEU:      taken = !lt;
            default:              taken = 1'b0;
        endcase
    end

    assign pc_sel          = taken ? PC_BRANCH : PC_ADD4;
    assign unsigned_cmp    = (cls.op == OP_BLTU) || (cls.op == OP_BGEU);
    assign link            = (cls.op == OP_BL);
    assign target_from_reg = (cls.op == OP_JIRL);

endmodule

// File: rtl/decode_stage.sv
module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  decode_pkg::instr_t     instr,
    input  logic                   eq,
    input  logic                   lt,
    output logic                   out_valid,
    output decode_pkg::pc_sel_t    pc_sel,
    output decode_pkg::imm_type_t  imm_type,
    output logic                   imm_unsigned,
    output decode_pkg::alu_src1_t  alu_src1,
    output decode_pkg::alu_src2_t  alu_src2,
    output decode_pkg::alu_op_t    alu_op,
    output decode_pkg::wb_sel_t    wb_sel,
    output logic                   reg_write_en,
    output logic                   mem_read,
    output logic                   mem_write_en,
    output decode_pkg::mem_size_t  mem_size,
    output logic                   load_unsigned,
    output logic                   unsigned_cmp,
    output logic                   link,
    output logic                   target_from_reg,
    output logic                   illegal
);
    import decode_pkg::*;

    pc_sel_t   d_pc_sel;
    imm_type_t d_imm_type;
    logic      d_imm_unsigned;
    alu_src1_t d_alu_src1;
    alu_src2_t d_alu_src2;
    alu_op_t   d_alu_op;
    wb_sel_t   d_wb_sel;
    logic      d_reg_write_en;
    logic      d_mem_read;
    logic      d_mem_write_en;
    mem_size_t d_mem_size;
    logic      d_load_unsigned;
    logic      d_unsigned_cmp;
    logic      d_link;
    logic      d_target_from_reg;

    instr_class_if cls ();

    opcode_decoder u_opcode_decoder (
        .instr (instr),
        .cls   (cls)
    );

    datapath_ctrl u_datapath_ctrl (
        .cls           (cls),
        .imm_type      (d_imm_type),
        .imm_unsigned  (d_imm_unsigned),
        .alu_src1      (d_alu_src1),
        .alu_src2      (d_alu_src2),
        .alu_op        (d_alu_op),
        .wb_sel        (d_wb_sel),
        .reg_write_en  (d_reg_write_en),
        .mem_read      (d_mem_read),
        .mem_write_en  (d_mem_write_en),
        .mem_size      (d_mem_size),
        .load_unsigned (d_load_unsigned)
    );

    branch_ctrl u_branch_ctrl (
        .cls             (cls),
        .eq              (eq),
        .lt              (lt),
        .pc_sel          (d_pc_sel),
        .unsigned_cmp    (d_unsigned_cmp),
        .link            (d_link),
        .target_from_reg (d_target_from_reg)
    );

    // anything that changes machine state is qualified by instr_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            pc_sel       <= PC_ADD4;
            reg_write_en <= 1'b0;
            mem_read     <= 1'b0;
            mem_write_en <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            out_valid    <= instr_valid;
            pc_sel       <= instr_valid ? d_pc_sel : PC_ADD4;
            reg_write_en <= instr_valid && d_reg_write_en;
            mem_read     <= instr_valid && d_mem_read;
            mem_write_en <= instr_valid && d_mem_write_en;
            illegal      <= instr_valid && cls.illegal;
        end
    end

    // operand and format fields, only meaningful with out_valid
    always_ff @(posedge clk) begin
        imm_type        <= d_imm_type;
        imm_unsigned    <= d_imm_unsigned;
        alu_src1        <= d_alu_src1;
        alu_src2        <= d_alu_src2;
        alu_op          <= d_alu_op;
        wb_sel          <= d_wb_sel;
        mem_size        <= d_mem_size;
        load_unsigned   <= d_load_unsigned;
        unsigned_cmp    <= d_unsigned_cmp;
        link            <= d_link;
        target_from_reg <= d_target_from_reg;
    end

    // a bubble never redirects fetch
    assert property (@(posedge clk) disable iff (rst)
        !out_valid |-> pc_sel == PC_ADD4)
        else $error("decode_stage: branch select on an empty slot");

endmodule

// File: test/tb_decode_stage.sv
`include "decode_config.svh"

module tb_decode_stage;
    import decode_pkg::*;

    // one registered control set, field order matches the checker's pattern
    typedef struct packed {
        logic      valid;
        logic      illegal;
        pc_sel_t   pc_sel;
        imm_type_t imm_type;
        logic      imm_unsigned;
        alu_src1_t alu_src1;
        alu_src2_t alu_src2;
        alu_op_t   alu_op;
        wb_sel_t   wb_sel;
        logic      reg_write_en;
        logic      mem_read;
        logic      mem_write_en;
        mem_size_t mem_size;
        logic      load_unsigned;
        logic      unsigned_cmp;
        logic      link;
        logic      target_from_reg;
    } ctrl_t;

    // fixed bits of each kept instruction, indexed by op_id_t
    localparam instr_t op_word [47] = '{
        {`DEC_3R_CODE, `DEC_ADD, 15'h0},    {`DEC_3R_CODE, `DEC_SUB, 15'h0},
        {`DEC_3R_CODE, `DEC_SLT, 15'h0},    {`DEC_3R_CODE, `DEC_SLTU, 15'h0},
        {`DEC_3R_CODE, `DEC_NOR, 15'h0},    {`DEC_3R_CODE, `DEC_AND, 15'h0},
        {`DEC_3R_CODE, `DEC_OR, 15'h0},     {`DEC_3R_CODE, `DEC_XOR, 15'h0},
        {`DEC_3R_CODE, `DEC_SLL, 15'h0},    {`DEC_3R_CODE, `DEC_SRL, 15'h0},
        {`DEC_3R_CODE, `DEC_SRA, 15'h0},    {`DEC_3R_CODE, `DEC_MUL, 15'h0},
        {`DEC_3R_CODE, `DEC_MULH, 15'h0},   {`DEC_3R_CODE, `DEC_MULHU, 15'h0},
        {`DEC_3R_CODE, `DEC_DIV, 15'h0},    {`DEC_3R_CODE, `DEC_MOD, 15'h0},
        {`DEC_3R_CODE, `DEC_DIVU, 15'h0},   {`DEC_3R_CODE, `DEC_MODU, 15'h0},
        {`DEC_2RI8_CODE, `DEC_SLLI, 15'h0}, {`DEC_2RI8_CODE, `DEC_SRLI, 15'h0},
        {`DEC_2RI8_CODE, `DEC_SRAI, 15'h0},
        {`DEC_2RI12_CODE, `DEC_SLTI, 22'h0}, {`DEC_2RI12_CODE, `DEC_SLTUI, 22'h0},
        {`DEC_2RI12_CODE, `DEC_ADDI, 22'h0}, {`DEC_2RI12_CODE, `DEC_ANDI, 22'h0},
        {`DEC_2RI12_CODE, `DEC_ORI, 22'h0},  {`DEC_2RI12_CODE, `DEC_XORI, 22'h0},
        {`DEC_U_CODE, `DEC_LUI, 25'h0},     {`DEC_U_CODE, `DEC_PCADDU12I, 25'h0},
        {`DEC_MEM_CODE, `DEC_LD_B, 22'h0},  {`DEC_MEM_CODE, `DEC_LD_H, 22'h0},
        {`DEC_MEM_CODE, `DEC_LD_W, 22'h0},  {`DEC_MEM_CODE, `DEC_LD_BU, 22'h0},
        {`DEC_MEM_CODE, `DEC_LD_HU, 22'h0}, {`DEC_MEM_CODE, `DEC_ST_B, 22'h0},
        {`DEC_MEM_CODE, `DEC_ST_H, 22'h0},  {`DEC_MEM_CODE, `DEC_ST_W, 22'h0},
        {`DEC_BR_CODE, `DEC_B, 26'h0},      {`DEC_BR_CODE, `DEC_BL, 26'h0},
        {`DEC_BR_CODE, `DEC_JIRL, 26'h0},   {`DEC_BR_CODE, `DEC_BEQ, 26'h0},
        {`DEC_BR_CODE, `DEC_BNE, 26'h0},    {`DEC_BR_CODE, `DEC_BLT, 26'h0},
        {`DEC_BR_CODE, `DEC_BGE, 26'h0},    {`DEC_BR_CODE, `DEC_BLTU, 26'h0},
        {`DEC_BR_CODE, `DEC_BGEU, 26'h0},
        // top bits 11 match no class
        32'hc000_0000
    };

    logic      clk;
    logic      rst;
    logic      instr_valid;
    instr_t    instr;
    logic      eq;
    logic      lt;
    logic      out_valid;
    pc_sel_t   pc_sel;
    imm_type_t imm_type;
    logic      imm_unsigned;
    alu_src1_t alu_src1;
    alu_src2_t alu_src2;
    alu_op_t   alu_op;
    wb_sel_t   wb_sel;
    logic      reg_write_en;
    logic      mem_read;
    logic      mem_write_en;
    mem_size_t mem_size;
    logic      load_unsigned;
    logic      unsigned_cmp;
    logic      link;
    logic      target_from_reg;
    logic      illegal;

    integer    seed;
    int        errors;
    int        checks;
    int        timeouts;
    int        wait_cycles;
    ctrl_t     exp_q[$];
    string     name_q[$];
    ctrl_t     exp_cur;
    ctrl_t     act_cur;
    string     name_cur;

    decode_stage dut_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // operand and immediate bits left random per class
    function automatic instr_t free_bits(op_id_t op);
        if (op <= OP_SRAI)
            return 32'h0000_7fff;
        else if (op <= OP_XORI)
            return 32'h003f_ffff;
        else if (op <= OP_PCADDU12I)
            return 32'h01ff_ffff;
        else if (op <= OP_ST_W)
            return 32'h003f_ffff;
        else if (op <= OP_BGEU)
            return 32'h03ff_ffff;
        return 32'h3fff_ffff;
    endfunction

    function automatic ctrl_t ref_decode(op_id_t op, instr_t w, logic eq_f, logic lt_f,
                                         logic v);
        ctrl_t c;
        logic  rd_nz;
        logic  taken;
        c = '0;
        rd_nz = (w[4:0] != 5'd0);
        taken = 1'b0;
        if (!v)
            return c;
        c.valid = 1'b1;
        if (op <= OP_MODU) begin
            c.alu_src1 = SRC1_RJ;
            c.alu_src2 = SRC2_RK;
            // register ops line up with the ALU codes
            c.alu_op = alu_op_t'(op[4:0]);
            c.reg_write_en = rd_nz;
        end else if (op <= OP_XORI) begin
            c.imm_type = (op <= OP_SRAI) ? IMM_I8 : IMM_I12;
            c.alu_src1 = SRC1_RJ;
            c.alu_src2 = SRC2_IMM;
            c.reg_write_en = rd_nz;
            c.imm_unsigned = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
            case (op)
                OP_SLLI:  c.alu_op = ALU_SLL;
                OP_SRLI:  c.alu_op = ALU_SRL;
                OP_SRAI:  c.alu_op = ALU_SRA;
                OP_SLTI:  c.alu_op = ALU_SLT;
                OP_SLTUI: c.alu_op = ALU_SLTU;
                OP_ANDI:  c.alu_op = ALU_AND;
                OP_ORI:   c.alu_op = ALU_OR;
                OP_XORI:  c.alu_op = ALU_XOR;
                default:  c.alu_op = ALU_ADD;
            endcase
        end else if (op <= OP_PCADDU12I) begin
            c.imm_type = IMM_I20;
            c.alu_src1 = (op == OP_PCADDU12I) ? SRC1_PC : SRC1_NONE;
            c.alu_src2 = SRC2_IMM;
            c.alu_op = (op == OP_LUI) ? ALU_LUI : ALU_ADD;
            c.reg_write_en = rd_nz;
        end else if (op <= OP_ST_W) begin
            // address is rj plus the offset
            c.imm_type = IMM_I12;
            c.alu_src1 = SRC1_RJ;
            c.alu_src2 = SRC2_IMM;
            c.alu_op = ALU_ADD;
            c.mem_read = (op <= OP_LD_HU);
            c.mem_write_en = (op >= OP_ST_B);
            c.reg_write_en = c.mem_read && rd_nz;
            c.wb_sel = c.mem_read ? WB_MEM : WB_ALU;
            c.load_unsigned = (op == OP_LD_BU) || (op == OP_LD_HU);
            if (op == OP_LD_H || op == OP_LD_HU || op == OP_ST_H)
                c.mem_size = SIZE_HALF;
            else if (op == OP_LD_W || op == OP_ST_W)
                c.mem_size = SIZE_WORD;
        end else if (op <= OP_JIRL) begin
            taken = 1'b1;
            c.imm_type = (op == OP_JIRL) ? IMM_I16 : IMM_I26;
            c.alu_src1 = (op == OP_B) ? SRC1_NONE : SRC1_PC;
            c.alu_op = (op == OP_B) ? ALU_ADD : ALU_PCADD4;
            // bl links to r1 whatever rd says
            c.reg_write_en = (op == OP_BL) || ((op == OP_JIRL) && rd_nz);
            c.link = (op == OP_BL);
            c.target_from_reg = (op == OP_JIRL);
        end else if (op <= OP_BGEU) begin
            c.imm_type = IMM_I16;
            c.unsigned_cmp = (op == OP_BLTU) || (op == OP_BGEU);
            case (op)
                OP_BEQ:          taken = eq_f;
                OP_BNE:          taken = !eq_f;
                OP_BLT, OP_BLTU: taken = lt_f;
                default:         taken = !lt_f;
            endcase
        end else begin
            c.illegal = 1'b1;
        end
        c.pc_sel = taken ? PC_BRANCH : PC_ADD4;
        return c;
    endfunction

    // fields that stay defined for bubbles and illegal words
    function automatic ctrl_t enables_only(ctrl_t c);
        ctrl_t m;
        m = '0;
        m.valid = c.valid;
        m.illegal = c.illegal;
        m.pc_sel = c.pc_sel;
        m.reg_write_en = c.reg_write_en;
        m.mem_read = c.mem_read;
        m.mem_write_en = c.mem_write_en;
        return m;
    endfunction

    function automatic string test_name(string phase, op_id_t op, logic v);
        if (phase != "mixed")
            return phase;
        if (!v)
            return "invalid_cycle";
        if (op == OP_ILLEGAL)
            return "illegal_word";
        if (op <= OP_PCADDU12I)
            return "alu_ops";
        if (op <= OP_ST_W)
            return "load_store";
        return "branch_jump";
    endfunction

    task automatic drive_cycle(string phase, logic hold_rst, logic rand_valid, logic valid_val);
        logic [31:0] pick;
        logic [31:0] bits;
        logic [31:0] ctl;
        op_id_t      op;
        instr_t      w;
        @(negedge clk);
        pick = $unsigned($random(seed)) % 32'd52;
        bits = $random(seed);
        ctl = $random(seed);
        op = (pick >= 32'd46) ? OP_ILLEGAL : op_id_t'(pick[5:0]);
        w = op_word[op] | (bits & free_bits(op));
        // unused minor codes inside real classes
        if (op == OP_ILLEGAL && ctl[6])
            w = {`DEC_3R_CODE, 7'h21, bits[14:0]};
        if (op == OP_ILLEGAL && ctl[7])
            w = {`DEC_2RI12_CODE, 3'b011, bits[21:0]};
        if (ctl[5:4] == 2'b00)
            w[`DEC_RD_FIELD] = 5'd0;
        rst = hold_rst;
        instr = w;
        eq = ctl[0];
        lt = ctl[1];
        instr_valid = rand_valid ? (ctl[3:2] != 2'b00) : valid_val;
        exp_q.push_back(ref_decode(op, w, eq, lt, instr_valid && !rst));
        name_q.push_back(test_name(phase, op, instr_valid));
    endtask

    // each entry is due one rising edge after it was driven
    always @(posedge clk) begin
        #2;
        if (exp_q.size() > 0) begin
            exp_cur = exp_q.pop_front();
            name_cur = name_q.pop_front();
            act_cur = '{out_valid, illegal, pc_sel, imm_type, imm_unsigned, alu_src1,
                        alu_src2, alu_op, wb_sel, reg_write_en, mem_read, mem_write_en,
                        mem_size, load_unsigned, unsigned_cmp, link, target_from_reg};
            if (!(exp_cur.valid && !exp_cur.illegal)) begin
                exp_cur = enables_only(exp_cur);
                act_cur = enables_only(act_cur);
            end
            checks++;
            if (act_cur !== exp_cur) begin
                errors++;
                $display("CHECK FAILED %s: expected %p actual %p", name_cur, exp_cur, act_cur);
            end
        end
    end

    initial begin
        seed = 32'heb93;
        errors = 0;
        checks = 0;
        timeouts = 0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        eq = 1'b0;
        lt = 1'b0;
        // busy inputs while reset holds, then a bubble right after
        for (int i = 0; i < 4; i++)
            drive_cycle("reset", 1'b1, 1'b0, 1'b1);
        drive_cycle("post_reset", 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 300; i++)
            drive_cycle("mixed", 1'b0, 1'b1, 1'b0);
        for (int i = 0; i < 200; i++)
            drive_cycle("back_to_back", 1'b0, 1'b0, 1'b1);
        wait_cycles = 0;
        while (exp_q.size() > 0 && wait_cycles < 10) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_q.size() > 0) begin
            timeouts++;
            $display("timeout: %0d results never came out of the DUT", exp_q.size());
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
rtl/decode_pkg.sv
rtl/instr_class_if.sv
rtl/opcode_decoder.sv
rtl/datapath_ctrl.sv
rtl/branch_ctrl.sv
rtl/decode_stage.sv
test/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_decode_stage -o tb_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_sim)
echo "$out"

echo "$out" | grep -qx "test passed" && exit 0 || { echo "simulation reported errors"; exit 1; }
